// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_ooo_core
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= TEST RESULT: FAIL
VFLAGS ?= --timing --assert

SOURCES := $(wildcard *.sv *.svh)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# a simulator that stops on its own counts as a failed run
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: add_sub_rs.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module add_sub_rs import ooo_pkg::*; (
	input logic clk,
	input logic reset,
	issue_if.target issue,
	input cdb_t cdb,
	cdb_if.initiator result
);
	localparam int DEPTH = `OOO_RS_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	typedef struct packed {
		logic valid;
		logic [`OOO_TAG_W-1:0] tag;
		alu_op_t op;
		logic sl2;
		cdb_t [1:0] opd;
	} entry_t;

	// entries are packed from index 0, index 0 is the oldest
	entry_t e [DEPTH];
	entry_t e_upd [DEPTH];
	entry_t e_nxt [DEPTH];
	entry_t e_raw;
	entry_t e_new;
	entry_t off;
	logic [DEPTH-1:0] rdy;
	logic [IDX_W-1:0] pick;
	logic leave;
	logic accept;

	// capture a matching broadcast into any operand still waiting
	function automatic entry_t snoop(entry_t en, cdb_t c);
		entry_t s;
		s = en;
		for (int j = 0; j < 2; j++) begin
			if (c.valid && !en.opd[j].valid && en.opd[j].tag == c.tag) begin
				s.opd[j].valid = 1'b1;
				s.opd[j].data = (j == 0 && en.sl2) ? c.data << 2 : c.data;
			end
		end
		return s;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// incoming entry and operand snooping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		e_raw.valid = 1'b1;
		e_raw.tag = issue.tag;
		e_raw.op = issue.op;
		e_raw.sl2 = issue.sl2;
		e_raw.opd = issue.opd;
		// rs is stored already shifted
		if (issue.sl2 && issue.opd[0].valid)
			e_raw.opd[0].data = issue.opd[0].data << 2;
	end
	assign e_new = snoop(e_raw, cdb);

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			e_upd[i] = snoop(e[i], cdb);
			rdy[i] = e[i].valid && e[i].opd[0].valid && e[i].opd[1].valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// dispatch to the arbiter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		pick = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (rdy[i])
				pick = IDX_W'(i);
		end
	end

	assign off = e[pick];
	assign result.valid = |rdy;
	assign result.tag = off.tag;
	assign result.data = (off.op == OP_SUB) ? off.opd[0].data - off.opd[1].data
		: off.opd[0].data + off.opd[1].data;

	assign leave = result.valid && result.ready;
	assign issue.ready = leave || !e[DEPTH-1].valid;
	assign accept = issue.valid && issue.ready;

	// keep the survivors in age order, then append the new entry
	always_comb begin
		int n;
		n = 0;
		for (int i = 0; i < DEPTH; i++)
			e_nxt[i] = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (e[i].valid && !(leave && pick == IDX_W'(i))) begin
				e_nxt[n] = e_upd[i];
				n++;
			end
		end
		if (accept)
			e_nxt[n] = e_new;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			e[i] <= e_nxt[i];
			if (reset)
				e[i].valid <= 1'b0;
		end
	end

	// an offered result stays offered until the arbiter takes it
	a_req_held: assert property (@(posedge clk) disable iff (reset)
		result.valid && !result.ready |=> result.valid)
		else $error("add_sub_rs: request dropped before its grant");

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module cdb_arbiter import ooo_pkg::*; (
	input logic clk,
	input logic reset,
	cdb_if.target req0,
	cdb_if.target req1,
	output cdb_t cdb
);
	// prio set means requester 1 wins a tie
	logic prio;
	logic grant0;
	logic grant1;

	assign grant0 = req0.valid && (!req1.valid || !prio);
	assign grant1 = req1.valid && (!req0.valid || prio);
	assign req0.ready = grant0;
	assign req1.ready = grant1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered broadcast
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			cdb.valid <= 1'b0;
			prio <= 1'b0;
		end else begin
			cdb.valid <= grant0 || grant1;
			// the loser of this grant gets the next tie
			if (grant0)
				prio <= 1'b1;
			else if (grant1)
				prio <= 1'b0;
		end
		cdb.tag <= grant1 ? req1.tag : req0.tag;
		cdb.data <= grant1 ? req1.data : req0.data;
	end

	// a station that loses a tie wins the next one
	a_rr_alternate: assert property (@(posedge clk) disable iff (reset)
		req0.valid && req1.valid |=>
		!(req0.valid && req1.valid) || req1.ready == $past(req0.ready))
		else $error("cdb_arbiter: the same station won two ties in a row");

endmodule

// File: issue_unit.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module issue_unit import ooo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input inst_word_u inst_word,
	output logic inst_ready,
	output logic [1:0][`OOO_REG_W-1:0] rd_addr,
	input cdb_t [1:0] rd_opd,
	output logic rename_en,
	output logic [`OOO_REG_W-1:0] rename_reg,
	output logic [`OOO_TAG_W-1:0] rename_tag,
	input cdb_t cdb,
	issue_if.initiator rs0,
	issue_if.initiator rs1
);
	localparam int N_TAGS = 1 << `OOO_TAG_W;

	logic [N_TAGS-1:0] free_tags;
	logic [`OOO_TAG_W-1:0] free_tag;
	logic any_free;
	logic imm_form;
	logic accept;
	cdb_t [1:0] opd;

	// lowest numbered free tag
	always_comb begin
		free_tag = '0;
		for (int t = N_TAGS - 1; t >= 0; t--) begin
			if (free_tags[t])
				free_tag = `OOO_TAG_W'(t);
		end
	end
	assign any_free = |free_tags;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode and operand read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign imm_form = inst_word.reg_f.op[0];
	assign rd_addr[0] = inst_word.reg_f.rs;
	assign rd_addr[1] = inst_word.reg_f.rt;

	always_comb begin
		opd = rd_opd;
		if (imm_form) begin
			opd[1].valid = 1'b1;
			opd[1].tag = '0;
			opd[1].data = `OOO_DATA_W'($signed(inst_word.imm_f.imm));
		end
	end

	// station 0 first, station 1 only when 0 is full
	assign rs0.valid = inst_valid && any_free && rs0.ready;
	assign rs1.valid = inst_valid && any_free && !rs0.ready;
	assign inst_ready = any_free && (rs0.ready || rs1.ready);
	assign accept = inst_valid && inst_ready;

	assign rs0.tag = free_tag;
	assign rs0.op = inst_word.reg_f.op[1] ? OP_SUB : OP_ADD;
	assign rs0.sl2 = inst_word.reg_f.op[2];
	assign rs0.opd = opd;
	assign rs1.tag = free_tag;
	assign rs1.op = inst_word.reg_f.op[1] ? OP_SUB : OP_ADD;
	assign rs1.sl2 = inst_word.reg_f.op[2];
	assign rs1.opd = opd;

	assign rename_en = accept;
	assign rename_reg = inst_word.reg_f.rd;
	assign rename_tag = free_tag;

	always_ff @(posedge clk) begin
		if (reset) begin
			free_tags <= '1;
		end else begin
			if (cdb.valid)
				free_tags[cdb.tag] <= 1'b1;
			if (accept)
				free_tags[free_tag] <= 1'b0;
		end
	end

	a_release_busy_tag: assert property (@(posedge clk) disable iff (reset)
		cdb.valid |-> !free_tags[cdb.tag])
		else $error("issue_unit: tag %0d broadcast while free", cdb.tag);

endmodule

// File: ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths and structure sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define OOO_DATA_W 32
// 3 bits of tag give 8 results in flight
`define OOO_TAG_W 3
`define OOO_REG_W 4
`define OOO_RS_DEPTH 2

`endif

// File: ooo_core.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core import ooo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input logic [31:0] inst_word,
	output logic cdb_valid,
	output logic [`OOO_TAG_W-1:0] cdb_tag,
	output logic [`OOO_DATA_W-1:0] cdb_data,
	input logic [`OOO_REG_W-1:0] dbg_addr,
	output logic [`OOO_DATA_W-1:0] dbg_data,
	output logic dbg_busy
);
	logic [1:0][`OOO_REG_W-1:0] rd_addr;
	cdb_t [1:0] rd_opd;
	logic rename_en;
	logic [`OOO_REG_W-1:0] rename_reg;
	logic [`OOO_TAG_W-1:0] rename_tag;
	cdb_t cdb;

	issue_if iss0 ();
	issue_if iss1 ();
	cdb_if res0 ();
	cdb_if res1 ();

	reg_status u_reg_status (
		.clk, .reset, .rd_addr, .rd_opd, .rename_en, .rename_reg, .rename_tag,
		.cdb, .dbg_addr, .dbg_data, .dbg_busy
	);

	issue_unit u_issue_unit (
		.clk, .reset, .inst_valid, .inst_word, .inst_ready,
		.rd_addr, .rd_opd, .rename_en, .rename_reg, .rename_tag,
		.cdb, .rs0(iss0), .rs1(iss1)
	);

	add_sub_rs rs0 (.clk, .reset, .issue(iss0), .cdb, .result(res0));
	add_sub_rs rs1 (.clk, .reset, .issue(iss1), .cdb, .result(res1));

	cdb_arbiter u_cdb_arbiter (.clk, .reset, .req0(res0), .req1(res1), .cdb);

	assign cdb_valid = cdb.valid;
	assign cdb_tag = cdb.tag;
	assign cdb_data = cdb.data;

endmodule

// File: ooo_ifs.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

// one decoded instruction on its way into a reservation station
interface issue_if import ooo_pkg::*; ();
	logic valid;
	logic ready;
	logic [`OOO_TAG_W-1:0] tag;
	alu_op_t op;
	logic sl2;
	cdb_t [1:0] opd;

	modport initiator (output valid, tag, op, sl2, opd, input ready);
	modport target (input valid, tag, op, sl2, opd, output ready);
endinterface

// a finished result asking for the CDB
interface cdb_if ();
	logic valid;
	logic ready;
	logic [`OOO_TAG_W-1:0] tag;
	logic [`OOO_DATA_W-1:0] data;

	modport initiator (output valid, tag, data, input ready);
	modport target (input valid, tag, data, output ready);
endinterface

// File: ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

	// an operand slot and the CDB broadcast share this record
	typedef struct packed {
		logic valid;
		logic [`OOO_TAG_W-1:0] tag;
		logic [`OOO_DATA_W-1:0] data;
	} cdb_t;

	typedef enum logic {
		OP_ADD,
		OP_SUB
	} alu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// op[0] immediate form, op[1] subtract, op[2] shift rs left by two
	typedef struct packed {
		logic [2:0] op;
		logic [`OOO_REG_W-1:0] rd;
		logic [`OOO_REG_W-1:0] rs;
		logic [`OOO_REG_W-1:0] rt;
		logic [16:0] pad;
	} inst_reg_t;

	typedef struct packed {
		logic [2:0] op;
		logic [`OOO_REG_W-1:0] rd;
		logic [`OOO_REG_W-1:0] rs;
		logic signed [15:0] imm;
		logic [4:0] pad;
	} inst_imm_t;

	typedef union packed {
		inst_reg_t reg_f;
		inst_imm_t imm_f;
	} inst_word_u;

endpackage

// File: reg_status.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reg_status import ooo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [1:0][`OOO_REG_W-1:0] rd_addr,
	output cdb_t [1:0] rd_opd,
	input logic rename_en,
	input logic [`OOO_REG_W-1:0] rename_reg,
	input logic [`OOO_TAG_W-1:0] rename_tag,
	input cdb_t cdb,
	input logic [`OOO_REG_W-1:0] dbg_addr,
	output logic [`OOO_DATA_W-1:0] dbg_data,
	output logic dbg_busy
);
	localparam int N_REGS = 1 << `OOO_REG_W;

	logic [N_REGS-1:0] busy;
	logic [`OOO_TAG_W-1:0] tags [N_REGS];
	logic [`OOO_DATA_W-1:0] vals [N_REGS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand read with CDB read-through
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			rd_opd[p].valid = !busy[rd_addr[p]];
			rd_opd[p].tag = tags[rd_addr[p]];
			rd_opd[p].data = vals[rd_addr[p]];
			// the producer is broadcasting right now, take its value directly
			if (busy[rd_addr[p]] && cdb.valid && cdb.tag == tags[rd_addr[p]]) begin
				rd_opd[p].valid = 1'b1;
				rd_opd[p].data = cdb.data;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rename and CDB capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < N_REGS; r++) begin
				busy[r] <= 1'b0;
				tags[r] <= '0;
				vals[r] <= '0;
			end
		end else begin
			for (int r = 0; r < N_REGS; r++) begin
				if (rename_en && rename_reg == `OOO_REG_W'(r)) begin
					// a newer producer takes over the register
					busy[r] <= 1'b1;
					tags[r] <= rename_tag;
				end else if (cdb.valid && busy[r] && tags[r] == cdb.tag) begin
					busy[r] <= 1'b0;
					vals[r] <= cdb.data;
				end
			end
		end
	end

	assign dbg_data = vals[dbg_addr];
	assign dbg_busy = busy[dbg_addr];

	// the free list must never hand out a tag that a register still waits on
	a_rename_fresh_tag: assert property (@(posedge clk) disable iff (reset)
		rename_en |-> !(busy[rename_reg] && tags[rename_reg] == rename_tag))
		else $error("reg_status: r%0d renamed to its own pending tag", rename_reg);

endmodule

// File: sim.f
+incdir+.
ooo_pkg.sv
ooo_ifs.sv
reg_status.sv
issue_unit.sv
add_sub_rs.sv
cdb_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

// File: tb_ooo_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random numbers and instruction words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_step(lfsr);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

function automatic logic [31:0] encode(input logic [2:0] op, input logic [`OOO_REG_W-1:0] rd,
	input logic [`OOO_REG_W-1:0] rs, input logic [`OOO_REG_W-1:0] rt, input logic [15:0] imm);
	inst_word_u w;
	w = '0;
	w.reg_f.op = op;
	w.reg_f.rd = rd;
	w.reg_f.rs = rs;
	if (op[0])
		w.imm_f.imm = imm;
	else
		w.reg_f.rt = rt;
	return w;
endfunction

// in-order execution of one instruction on the model registers
task automatic model_exec(input inst_word_u w);
	logic [`OOO_DATA_W-1:0] a;
	logic [`OOO_DATA_W-1:0] b;
	logic [`OOO_DATA_W-1:0] r;
	a = mreg[w.reg_f.rs];
	if (w.reg_f.op[2])
		a = a << 2;
	if (w.reg_f.op[0])
		b = {{16{w.imm_f.imm[15]}}, w.imm_f.imm};
	else
		b = mreg[w.reg_f.rt];
	r = w.reg_f.op[1] ? a - b : a + b;
	mreg[w.reg_f.rd] = r;
	exp_q.push_back(r);
endtask

// the issue side hands out the lowest numbered free tag
function automatic logic [`OOO_TAG_W-1:0] lowest_free(input logic [(1 << `OOO_TAG_W)-1:0] f);
	logic [`OOO_TAG_W-1:0] t;
	logic found;
	t = '0;
	found = 1'b0;
	for (int i = 0; i < (1 << `OOO_TAG_W); i++) begin
		if (!found && f[i]) begin
			t = `OOO_TAG_W'(i);
			found = 1'b1;
		end
	end
	return t;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshakes and waits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// called on a falling edge and returns on the falling edge after acceptance
task automatic issue_word(input logic [31:0] w);
	int waited;
	waited = 0;
	inst_valid = 1'b1;
	inst_word = w;
	while (!inst_ready && !aborted) begin
		@(negedge clk);
		waited++;
		if (waited > TIMEOUT) begin
			$display("timeout: instruction %h never accepted in %s", w, cur_test);
			aborted = 1'b1;
			err_cnt++;
		end
	end
	@(negedge clk);
	inst_valid = 1'b0;
endtask

task automatic send(input logic [31:0] w);
	model_exec(w);
	issue_word(w);
	sent_cnt++;
endtask

task automatic wait_broadcasts(input int n);
	int waited;
	waited = 0;
	while (bcast_cnt - bcast_base < n && !aborted) begin
		@(negedge clk);
		waited++;
		if (waited > TIMEOUT) begin
			$display("timeout: only %0d of %0d broadcasts seen in %s",
				bcast_cnt - bcast_base, n, cur_test);
			aborted = 1'b1;
			err_cnt++;
		end
	end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_data(input string what, input logic [`OOO_DATA_W-1:0] exp,
	input logic [`OOO_DATA_W-1:0] act);
	if (exp !== act) begin
		$display("error %s %s expected %h actual %h", cur_test, what, exp, act);
		err_cnt++;
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	if (exp !== act) begin
		$display("error %s %s expected %b actual %b", cur_test, what, exp, act);
		err_cnt++;
	end
endtask

// File: tb_ooo_core.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo_core import ooo_pkg::*; ();
	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic reset;
	logic inst_valid;
	logic inst_ready;
	logic [31:0] inst_word;
	logic cdb_valid;
	logic [`OOO_TAG_W-1:0] cdb_tag;
	logic [`OOO_DATA_W-1:0] cdb_data;
	logic [`OOO_REG_W-1:0] dbg_addr;
	logic [`OOO_DATA_W-1:0] dbg_data;
	logic dbg_busy;

	logic [31:0] lfsr = 32'h2188;
	logic [`OOO_DATA_W-1:0] mreg [16];
	logic [`OOO_DATA_W-1:0] exp_q [$];
	logic [`OOO_DATA_W-1:0] got_q [$];
	logic [(1 << `OOO_TAG_W)-1:0] tag_free;
	int sent_cnt;
	int bcast_cnt;
	int bcast_base;
	int err_cnt;
	int test_errs;
	int tests_run;
	int tests_failed;
	logic aborted;
	string cur_test;

	`include "tb_ooo_tasks.svh"

	ooo_core UUT (.*);

	always #10 clk = ~clk;

	// the broadcast of the cycle that is just ending, and the tags in flight
	always @(posedge clk) begin
		logic [`OOO_TAG_W-1:0] alloc;
		if (reset) begin
			tag_free = '1;
		end else begin
			alloc = lowest_free(tag_free);
			if (cdb_valid) begin
				got_q.push_back(cdb_data);
				bcast_cnt++;
				check_flag($sformatf("tag %0d free", cdb_tag), 1'b0, tag_free[cdb_tag]);
				tag_free[cdb_tag] = 1'b1;
			end
			if (inst_valid && inst_ready)
				tag_free[alloc] = 1'b0;
		end
	end

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = err_cnt;
		sent_cnt = 0;
		bcast_base = bcast_cnt;
		exp_q.delete();
	endtask

	task automatic end_test();
		tests_run++;
		if (err_cnt == test_errs) begin
			$display("%s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, err_cnt - test_errs);
		end
	endtask

	// wait for every result, then compare broadcasts and registers with the model
	task automatic drain_and_check();
		logic [`OOO_DATA_W-1:0] seen [$];
		wait_broadcasts(sent_cnt);
		repeat (4) @(negedge clk);
		for (int k = bcast_base; k < got_q.size(); k++)
			seen.push_back(got_q[k]);
		check_data("broadcast count", `OOO_DATA_W'(sent_cnt), `OOO_DATA_W'(seen.size()));
		foreach (exp_q[i]) begin
			logic found;
			found = 1'b0;
			for (int k = 0; k < seen.size(); k++) begin
				if (!found && seen[k] === exp_q[i]) begin
					seen.delete(k);
					found = 1'b1;
				end
			end
			check_flag($sformatf("broadcast of %h", exp_q[i]), 1'b1, found);
		end
		for (int r = 0; r < 16; r++) begin
			dbg_addr = `OOO_REG_W'(r);
			#2;
			check_data($sformatf("r%0d", r), mreg[r], dbg_data);
			check_flag($sformatf("r%0d busy", r), 1'b0, dbg_busy);
			@(negedge clk);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// r0 is loaded first so that every later load adds its value
	task automatic test_imm_loads();
		start_test("imm_loads");
		for (int r = 0; r < 16; r++)
			send(encode(3'b001, `OOO_REG_W'(r), 4'd0, 4'd0, 16'(rand_bits(16))));
		drain_and_check();
		end_test();
	endtask

	// sources in r0..r7 are never written here, so the operations are independent
	task automatic test_reg_ops(input string name, input logic sl2);
		logic [2:0] op;
		start_test(name);
		for (int i = 0; i < 8; i++) begin
			op = {sl2, 2'b00} | 3'(rand_bits(1) << 1);
			send(encode(op, `OOO_REG_W'(8 + i), 4'(rand_bits(3)), 4'(rand_bits(3)), 16'd0));
		end
		drain_and_check();
		end_test();
	endtask

	task automatic test_chain();
		logic [`OOO_REG_W-1:0] prev;
		logic [`OOO_REG_W-1:0] rd;
		start_test("dependency_chain");
		prev = 4'd1;
		for (int i = 0; i < 10; i++) begin
			rd = 4'(rand_bits(4));
			send(encode(3'(rand_bits(3)), rd, prev, 4'(rand_bits(4)), 16'(rand_bits(16))));
			prev = rd;
		end
		drain_and_check();
		end_test();
	endtask

	task automatic test_backpressure();
		start_test("backpressure");
		for (int i = 0; i < 8; i++)
			send(encode(3'(rand_bits(2) << 1), 4'd2, 4'd2, 4'(12 + rand_bits(2)), 16'd0));
		for (int i = 0; i < 12; i++)
			send(encode(3'(rand_bits(2) << 1) | 3'b001, `OOO_REG_W'(8 + i % 4),
				4'(4 + rand_bits(2)), 4'd0, 16'(rand_bits(16))));
		drain_and_check();
		end_test();
	endtask

	// the later write to r5 waits on the r1 chain, so it is the last broadcast
	task automatic test_rename();
		start_test("rename_override");
		for (int i = 0; i < 3; i++)
			send(encode(3'b000, 4'd1, 4'd1, 4'd2, 16'd0));
		send(encode(3'b001, 4'd5, 4'd0, 4'd0, 16'(rand_bits(16))));
		send(encode(3'b000, 4'd5, 4'd1, 4'd3, 16'd0));
		wait_broadcasts(sent_cnt - 1);
		dbg_addr = 4'd5;
		#2;
		check_flag("r5 busy before the later write", 1'b1, dbg_busy);
		drain_and_check();
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_word = '0;
		dbg_addr = '0;
		aborted = 1'b0;
		for (int r = 0; r < 16; r++)
			mreg[r] = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		test_imm_loads();
		test_reg_ops("add_sub", 1'b0);
		test_reg_ops("shift_rs", 1'b1);
		test_chain();
		test_backpressure();
		test_rename();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
